// ==== all.f ====
+incdir+hdl
hdl/ip_switch_pkg.sv
hdl/ip_stream_if.sv
hdl/ip_rx_classifier.sv
hdl/ip_tx_arbiter.sv
hdl/ip_proto_switch.sv
tests/ip_proto_switch_asserts.sv
tests/ip_proto_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module ip_proto_switch_tb -o sim
./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

// ==== tests/ip_proto_switch_tb.sv ====
`include "ip_switch_cfg.svh"

module ip_proto_switch_tb;
  import ip_switch_pkg::*;

  localparam int RX_FRAMES  = 40;
  localparam int TX_FRAMES  = 30;
  localparam int WAIT_LIMIT = 300;
  localparam int HDR_W      = $bits(ip_hdr_t);

  logic clk = 1'b0;
  logic rst;

  logic rx_in_hdr_valid, rx_in_hdr_ready, rx_in_tvalid, rx_in_tready, rx_in_tlast, rx_in_tuser;
  logic rx_udp_hdr_valid, rx_udp_hdr_ready, rx_udp_tvalid, rx_udp_tready;
  logic rx_udp_tlast, rx_udp_tuser;
  logic rx_other_hdr_valid, rx_other_hdr_ready, rx_other_tvalid, rx_other_tready;
  logic rx_other_tlast, rx_other_tuser;
  logic tx_out_hdr_valid, tx_out_hdr_ready, tx_out_tvalid, tx_out_tready;
  logic tx_out_tlast, tx_out_tuser;
  logic rx_busy, tx_busy;
  ip_hdr_t rx_in_hdr, rx_udp_hdr, rx_other_hdr, tx_out_hdr;
  logic [`IP_DATA_W-1:0] rx_in_tdata, rx_udp_tdata, rx_other_tdata, tx_out_tdata;
  logic [`IP_KEEP_W-1:0] rx_in_tkeep, rx_udp_tkeep, rx_other_tkeep, tx_out_tkeep;

  // Transmit sources, index 0 is UDP and 1 is raw
  logic                  src_hdr_valid [2];
  logic                  src_hdr_ready [2];
  ip_hdr_t               src_hdr [2];
  logic [`IP_DATA_W-1:0] src_tdata [2];
  logic [`IP_KEEP_W-1:0] src_tkeep [2];
  logic                  src_tvalid [2];
  logic                  src_tready [2];
  logic                  src_tlast [2];
  logic                  src_tuser [2];

  ip_proto_switch ip_proto_switch_inst (
    .*,
    .tx_udp_hdr_valid (src_hdr_valid[0]),
    .tx_udp_hdr_ready (src_hdr_ready[0]),
    .tx_udp_hdr       (src_hdr[0]),
    .tx_udp_tdata     (src_tdata[0]),
    .tx_udp_tkeep     (src_tkeep[0]),
    .tx_udp_tvalid    (src_tvalid[0]),
    .tx_udp_tready    (src_tready[0]),
    .tx_udp_tlast     (src_tlast[0]),
    .tx_udp_tuser     (src_tuser[0]),
    .tx_raw_hdr_valid (src_hdr_valid[1]),
    .tx_raw_hdr_ready (src_hdr_ready[1]),
    .tx_raw_hdr       (src_hdr[1]),
    .tx_raw_tdata     (src_tdata[1]),
    .tx_raw_tkeep     (src_tkeep[1]),
    .tx_raw_tvalid    (src_tvalid[1]),
    .tx_raw_tready    (src_tready[1]),
    .tx_raw_tlast     (src_tlast[1]),
    .tx_raw_tuser     (src_tuser[1])
  );

  bind ip_proto_switch ip_proto_switch_asserts asserts_inst (.*);

  always #10 clk = ~clk;

  // Output readies, high three times in four
  always @(posedge clk) begin
    rx_udp_hdr_ready   <= ($urandom_range(0, 3) != 0);
    rx_udp_tready      <= ($urandom_range(0, 3) != 0);
    rx_other_hdr_ready <= ($urandom_range(0, 3) != 0);
    rx_other_tready    <= ($urandom_range(0, 3) != 0);
    tx_out_hdr_ready   <= ($urandom_range(0, 3) != 0);
    tx_out_tready      <= ($urandom_range(0, 3) != 0);
  end

  task automatic abort_run(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  always @(negedge clk) begin
    if (ip_proto_switch_inst.asserts_inst.fail_count != 0) begin
      abort_run("An assertion on the DUT failed");
    end
  end

  function automatic logic channel_ready(input int ch);
    case (ch)
      0: return rx_in_hdr_ready;
      1: return rx_in_tready;
      2: return src_hdr_ready[0];
      3: return src_hdr_ready[1];
      4: return src_tready[0];
      5: return src_tready[1];
      default: return !rx_busy && !tx_busy;
    endcase
  endfunction

  // Returns on the clock edge that completes the handshake
  task automatic wait_ready(input int ch, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!channel_ready(ch) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!channel_ready(ch)) begin
      abort_run({"Timed out waiting for ", what});
    end
    @(posedge clk);
  endtask

  function automatic ip_hdr_t random_hdr();
    return HDR_W'({$urandom(), $urandom(), $urandom(), $urandom()});
  endfunction

  task automatic send_rx_frame(input logic [7:0] proto, input int beats);
    ip_hdr_t hdr;
    hdr = random_hdr();
    hdr.protocol = proto;
    @(posedge clk);
    rx_in_hdr_valid <= 1'b1;
    rx_in_hdr       <= hdr;
    wait_ready(0, "rx_in header accept");
    rx_in_hdr_valid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      rx_in_tvalid <= 1'b1;
      rx_in_tdata  <= {proto, 24'($urandom()), $urandom()};
      rx_in_tkeep  <= `IP_KEEP_W'($urandom());
      rx_in_tlast  <= (i == beats - 1);
      rx_in_tuser  <= 1'($urandom());
      wait_ready(1, "rx_in payload accept");
    end
    rx_in_tvalid <= 1'b0;
    rx_in_tlast  <= 1'b0;
  endtask

  task automatic send_tx_frame(input int src, input int beats);
    logic [7:0] tag;
    tag = (src == 0) ? 8'hAA : 8'hBB;
    @(posedge clk);
    src_hdr_valid[src] <= 1'b1;
    src_hdr[src]       <= random_hdr();
    wait_ready(2 + src, "transmit header accept");
    src_hdr_valid[src] <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      src_tvalid[src] <= 1'b1;
      src_tdata[src]  <= {tag, 24'($urandom()), $urandom()};
      src_tkeep[src]  <= `IP_KEEP_W'($urandom());
      src_tlast[src]  <= (i == beats - 1);
      src_tuser[src]  <= 1'($urandom());
      wait_ready(4 + src, "transmit payload accept");
    end
    src_tvalid[src] <= 1'b0;
    src_tlast[src]  <= 1'b0;
  endtask

  task automatic run_rx();
    logic [7:0] proto;
    for (int n = 0; n < RX_FRAMES; n++) begin
      if ($urandom_range(0, 1) != 0) begin
        proto = 8'(`IP_PROTO_UDP);
      end else begin
        proto = 8'($urandom());
      end
      send_rx_frame(proto, $urandom_range(1, 4));
      repeat ($urandom_range(0, 2)) @(posedge clk);
    end
  endtask

  task automatic run_tx(input int src);
    for (int n = 0; n < TX_FRAMES; n++) begin
      send_tx_frame(src, $urandom_range(1, 4));
      repeat ($urandom_range(0, 2)) @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h4715));
    rst = 1'b1;
    rx_in_hdr_valid = 1'b0;
    rx_in_hdr = '0;
    rx_in_tdata = '0;
    rx_in_tkeep = '1;
    rx_in_tvalid = 1'b0;
    rx_in_tlast = 1'b0;
    rx_in_tuser = 1'b0;
    rx_udp_hdr_ready = 1'b0;
    rx_udp_tready = 1'b0;
    rx_other_hdr_ready = 1'b0;
    rx_other_tready = 1'b0;
    tx_out_hdr_ready = 1'b0;
    tx_out_tready = 1'b0;
    for (int s = 0; s < 2; s++) begin
      src_hdr_valid[s] = 1'b0;
      src_hdr[s] = '0;
      src_tdata[s] = '0;
      src_tkeep[s] = '1;
      src_tvalid[s] = 1'b0;
      src_tlast[s] = 1'b0;
      src_tuser[s] = 1'b0;
    end

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    fork
      run_rx();
      run_tx(0);
      run_tx(1);
    join

    wait_ready(6, "both paths to return to idle");
    repeat (2) @(posedge clk);
    if (ip_proto_switch_inst.asserts_inst.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("Assertion failures were recorded during the run");
    end
  end

endmodule

// ==== tests/ip_proto_switch_asserts.sv ====
`include "ip_switch_cfg.svh"

module ip_proto_switch_asserts (
  input logic                   clk,
  input logic                   rst,
  input logic                   rx_in_hdr_ready,
  input ip_switch_pkg::ip_hdr_t rx_in_hdr,
  input logic [`IP_DATA_W-1:0]  rx_in_tdata,
  input logic [`IP_KEEP_W-1:0]  rx_in_tkeep,
  input logic                   rx_in_tvalid, rx_in_tready, rx_in_tlast, rx_in_tuser,
  input logic                   rx_udp_hdr_valid, rx_udp_hdr_ready,
  input ip_switch_pkg::ip_hdr_t rx_udp_hdr,
  input logic                   rx_udp_tvalid, rx_udp_tready,
  input logic [`IP_DATA_W-1:0]  rx_udp_tdata,
  input logic [`IP_KEEP_W-1:0]  rx_udp_tkeep,
  input logic                   rx_udp_tlast, rx_udp_tuser,
  input logic                   rx_other_hdr_valid, rx_other_hdr_ready,
  input ip_switch_pkg::ip_hdr_t rx_other_hdr,
  input logic                   rx_other_tvalid, rx_other_tready,
  input logic [`IP_DATA_W-1:0]  rx_other_tdata,
  input logic [`IP_KEEP_W-1:0]  rx_other_tkeep,
  input logic                   rx_other_tlast, rx_other_tuser,
  input logic                   tx_udp_hdr_valid, tx_raw_hdr_valid,
  input logic                   tx_udp_hdr_ready, tx_raw_hdr_ready,
  input ip_switch_pkg::ip_hdr_t tx_udp_hdr,
  input logic [`IP_DATA_W-1:0]  tx_udp_tdata, tx_raw_tdata,
  input logic [`IP_KEEP_W-1:0]  tx_udp_tkeep, tx_raw_tkeep,
  input logic                   tx_udp_tready, tx_udp_tlast, tx_udp_tuser,
  input logic                   tx_raw_tready, tx_raw_tlast, tx_raw_tuser,
  input logic                   tx_out_hdr_valid,
  input ip_switch_pkg::ip_hdr_t tx_out_hdr,
  input logic                   tx_out_tvalid, tx_out_tready, tx_out_tlast, tx_out_tuser,
  input logic [`IP_DATA_W-1:0]  tx_out_tdata,
  input logic [`IP_KEEP_W-1:0]  tx_out_tkeep,
  input logic                   rx_busy, tx_busy
);
  import ip_switch_pkg::*;

  localparam int BEAT_W = `IP_DATA_W + `IP_KEEP_W + 2;

  int        fail_count = 0;
  rx_route_e route;
  logic      tx_in_frame;
  logic [7:0] tx_tag;
  logic      tx_tag_udp;
  logic [BEAT_W-1:0] rx_in_beat;
  logic [BEAT_W-1:0] rx_udp_beat;
  logic [BEAT_W-1:0] rx_other_beat;
  logic [BEAT_W-1:0] tx_udp_beat;
  logic [BEAT_W-1:0] tx_raw_beat;
  logic [BEAT_W-1:0] tx_out_beat;

  assign rx_in_beat    = {rx_in_tdata, rx_in_tkeep, rx_in_tlast, rx_in_tuser};
  assign rx_udp_beat   = {rx_udp_tdata, rx_udp_tkeep, rx_udp_tlast, rx_udp_tuser};
  assign rx_other_beat = {rx_other_tdata, rx_other_tkeep, rx_other_tlast, rx_other_tuser};
  assign tx_udp_beat   = {tx_udp_tdata, tx_udp_tkeep, tx_udp_tlast, tx_udp_tuser};
  assign tx_raw_beat   = {tx_raw_tdata, tx_raw_tkeep, tx_raw_tlast, tx_raw_tuser};
  assign tx_out_beat   = {tx_out_tdata, tx_out_tkeep, tx_out_tlast, tx_out_tuser};

  // Top byte names the transmit source
  assign tx_tag_udp = (tx_out_tdata[`IP_DATA_W-1 -: 8] == 8'hAA);

  // Route seen from the output header handshakes
  always_ff @(posedge clk) begin
    if (rst) begin
      route <= route_idle;
    end else if (rx_udp_hdr_valid && rx_udp_hdr_ready) begin
      route <= route_udp;
    end else if (rx_other_hdr_valid && rx_other_hdr_ready) begin
      route <= route_other;
    end else if (rx_in_tvalid && rx_in_tready && rx_in_tlast) begin
      route <= route_idle;
    end
  end

  // Tag of the first beat of the current tx_out frame
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_in_frame <= 1'b0;
      tx_tag      <= 8'h00;
    end else if (tx_out_tvalid && tx_out_tready) begin
      tx_in_frame <= !tx_out_tlast;
      if (!tx_in_frame) begin
        tx_tag <= tx_out_tdata[`IP_DATA_W-1 -: 8];
      end
    end
  end

  assert property (@(posedge clk) $past(rst) |->
      !(rx_udp_hdr_valid || rx_other_hdr_valid || rx_udp_tvalid || rx_other_tvalid ||
        tx_out_hdr_valid || tx_out_tvalid || rx_busy || tx_busy))
    else begin
      $error("Output valid or busy was high during or just after reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_udp_tvalid && rx_udp_tready |->
      rx_udp_tdata[`IP_DATA_W-1 -: 8] == 8'(`IP_PROTO_UDP))
    else begin
      $error("FAILED %0t rx_udp_tdata top byte %0d expected %0d", $time,
             rx_udp_tdata[`IP_DATA_W-1 -: 8], `IP_PROTO_UDP);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_other_tvalid && rx_other_tready |->
      rx_other_tdata[`IP_DATA_W-1 -: 8] != 8'(`IP_PROTO_UDP))
    else begin
      $error("FAILED %0t rx_other_tdata top byte %0d expected not %0d", $time,
             rx_other_tdata[`IP_DATA_W-1 -: 8], `IP_PROTO_UDP);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) !(rx_udp_hdr_valid && rx_other_hdr_valid))
    else begin
      $error("Both rx_udp and rx_other header valids were high together");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_udp_hdr_valid |->
      rx_udp_hdr.protocol == 8'(`IP_PROTO_UDP))
    else begin
      $error("FAILED %0t rx_udp_hdr.protocol %0d expected %0d", $time,
             rx_udp_hdr.protocol, `IP_PROTO_UDP);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_in_hdr_ready |->
      route == route_idle)
    else begin
      $error("rx_in_hdr_ready was high while a payload was in progress");
      fail_count++;
    end

  // Routed outputs carry the input header and beats unchanged
  assert property (@(posedge clk) disable iff (rst) rx_udp_hdr_valid |->
      rx_udp_hdr == rx_in_hdr)
    else begin
      $error("FAILED %0t rx_udp_hdr %h expected %h", $time, rx_udp_hdr, rx_in_hdr);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_other_hdr_valid |->
      rx_other_hdr == rx_in_hdr)
    else begin
      $error("FAILED %0t rx_other_hdr %h expected %h", $time, rx_other_hdr, rx_in_hdr);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_udp_tvalid |->
      rx_udp_beat == rx_in_beat)
    else begin
      $error("FAILED %0t rx_udp_beat %h expected %h", $time, rx_udp_beat, rx_in_beat);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_other_tvalid |->
      rx_other_beat == rx_in_beat)
    else begin
      $error("FAILED %0t rx_other_beat %h expected %h", $time, rx_other_beat, rx_in_beat);
      fail_count++;
    end

  // UDP wins when both headers wait on an idle arbiter
  assert property (@(posedge clk) disable iff (rst)
      tx_udp_hdr_valid && tx_raw_hdr_valid && !tx_busy |=>
      tx_out_hdr_valid && tx_out_hdr == $past(tx_udp_hdr))
    else begin
      $error("FAILED %0t tx_out_hdr %h expected %h", $time, tx_out_hdr, tx_udp_hdr);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
      tx_out_tvalid && tx_out_tready && tx_in_frame |->
      tx_out_tdata[`IP_DATA_W-1 -: 8] == tx_tag)
    else begin
      $error("FAILED %0t tx_out_tdata tag %h expected %h", $time,
             tx_out_tdata[`IP_DATA_W-1 -: 8], tx_tag);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) tx_out_tvalid |->
      tx_out_beat == (tx_tag_udp ? tx_udp_beat : tx_raw_beat))
    else begin
      $error("FAILED %0t tx_out_beat %h expected %h", $time, tx_out_beat,
             tx_tag_udp ? tx_udp_beat : tx_raw_beat);
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) tx_out_tvalid && tx_out_tready |->
      (tx_tag_udp ? tx_udp_tready : tx_raw_tready))
    else begin
      $error("A tx_out beat was accepted while its own source saw tready low");
      fail_count++;
    end

  // The ungranted source sees no ready at all
  assert property (@(posedge clk) disable iff (rst)
      !((tx_udp_hdr_ready || tx_udp_tready) && (tx_raw_hdr_ready || tx_raw_tready)))
    else begin
      $error("Both transmit sources saw a ready in the same cycle");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) rx_in_tready |->
      (route == route_udp && rx_udp_tready) || (route == route_other && rx_other_tready))
    else begin
      $error("rx_in_tready was high while the routed output was not ready");
      fail_count++;
    end

endmodule

// ==== hdl/ip_proto_switch.sv ====
`include "ip_switch_cfg.svh"

module ip_proto_switch (
  input  logic                   clk,
  input  logic                   rst,

  // Received IP frames
  input  logic                   rx_in_hdr_valid,
  output logic                   rx_in_hdr_ready,
  input  ip_switch_pkg::ip_hdr_t rx_in_hdr,
  input  logic [`IP_DATA_W-1:0]  rx_in_tdata,
  input  logic [`IP_KEEP_W-1:0]  rx_in_tkeep,
  input  logic                   rx_in_tvalid, rx_in_tlast, rx_in_tuser,
  output logic                   rx_in_tready,

  // Protocol 17 frames
  output logic                   rx_udp_hdr_valid,
  input  logic                   rx_udp_hdr_ready,
  output ip_switch_pkg::ip_hdr_t rx_udp_hdr,
  output logic [`IP_DATA_W-1:0]  rx_udp_tdata,
  output logic [`IP_KEEP_W-1:0]  rx_udp_tkeep,
  output logic                   rx_udp_tvalid, rx_udp_tlast, rx_udp_tuser,
  input  logic                   rx_udp_tready,

  // Every other protocol
  output logic                   rx_other_hdr_valid,
  input  logic                   rx_other_hdr_ready,
  output ip_switch_pkg::ip_hdr_t rx_other_hdr,
  output logic [`IP_DATA_W-1:0]  rx_other_tdata,
  output logic [`IP_KEEP_W-1:0]  rx_other_tkeep,
  output logic                   rx_other_tvalid, rx_other_tlast, rx_other_tuser,
  input  logic                   rx_other_tready,

  input  logic                   tx_udp_hdr_valid,
  output logic                   tx_udp_hdr_ready,
  input  ip_switch_pkg::ip_hdr_t tx_udp_hdr,
  input  logic [`IP_DATA_W-1:0]  tx_udp_tdata,
  input  logic [`IP_KEEP_W-1:0]  tx_udp_tkeep,
  input  logic                   tx_udp_tvalid, tx_udp_tlast, tx_udp_tuser,
  output logic                   tx_udp_tready,

  input  logic                   tx_raw_hdr_valid,
  output logic                   tx_raw_hdr_ready,
  input  ip_switch_pkg::ip_hdr_t tx_raw_hdr,
  input  logic [`IP_DATA_W-1:0]  tx_raw_tdata,
  input  logic [`IP_KEEP_W-1:0]  tx_raw_tkeep,
  input  logic                   tx_raw_tvalid, tx_raw_tlast, tx_raw_tuser,
  output logic                   tx_raw_tready,

  // Merged transmit stream
  output logic                   tx_out_hdr_valid,
  input  logic                   tx_out_hdr_ready,
  output ip_switch_pkg::ip_hdr_t tx_out_hdr,
  output logic [`IP_DATA_W-1:0]  tx_out_tdata,
  output logic [`IP_KEEP_W-1:0]  tx_out_tkeep,
  output logic                   tx_out_tvalid, tx_out_tlast, tx_out_tuser,
  input  logic                   tx_out_tready,

  output logic                   rx_busy,
  output logic                   tx_busy
);

  ip_stream_if rx_in ();
  ip_stream_if rx_udp ();
  ip_stream_if rx_other ();
  ip_stream_if tx_udp ();
  ip_stream_if tx_raw ();
  ip_stream_if tx_out ();

  assign rx_in.hdr_valid = rx_in_hdr_valid;
  assign rx_in_hdr_ready = rx_in.hdr_ready;
  assign rx_in.hdr       = rx_in_hdr;
  assign rx_in.tdata     = rx_in_tdata;
  assign rx_in.tkeep     = rx_in_tkeep;
  assign rx_in.tvalid    = rx_in_tvalid;
  assign rx_in_tready    = rx_in.tready;
  assign rx_in.tlast     = rx_in_tlast;
  assign rx_in.tuser     = rx_in_tuser;

  assign rx_udp_hdr_valid = rx_udp.hdr_valid;
  assign rx_udp.hdr_ready = rx_udp_hdr_ready;
  assign rx_udp_hdr       = rx_udp.hdr;
  assign rx_udp_tdata     = rx_udp.tdata;
  assign rx_udp_tkeep     = rx_udp.tkeep;
  assign rx_udp_tvalid    = rx_udp.tvalid;
  assign rx_udp.tready    = rx_udp_tready;
  assign rx_udp_tlast     = rx_udp.tlast;
  assign rx_udp_tuser     = rx_udp.tuser;

  assign rx_other_hdr_valid = rx_other.hdr_valid;
  assign rx_other.hdr_ready = rx_other_hdr_ready;
  assign rx_other_hdr       = rx_other.hdr;
  assign rx_other_tdata     = rx_other.tdata;
  assign rx_other_tkeep     = rx_other.tkeep;
  assign rx_other_tvalid    = rx_other.tvalid;
  assign rx_other.tready    = rx_other_tready;
  assign rx_other_tlast     = rx_other.tlast;
  assign rx_other_tuser     = rx_other.tuser;

  assign tx_udp.hdr_valid = tx_udp_hdr_valid;
  assign tx_udp_hdr_ready = tx_udp.hdr_ready;
  assign tx_udp.hdr       = tx_udp_hdr;
  assign tx_udp.tdata     = tx_udp_tdata;
  assign tx_udp.tkeep     = tx_udp_tkeep;
  assign tx_udp.tvalid    = tx_udp_tvalid;
  assign tx_udp_tready    = tx_udp.tready;
  assign tx_udp.tlast     = tx_udp_tlast;
  assign tx_udp.tuser     = tx_udp_tuser;

  assign tx_raw.hdr_valid = tx_raw_hdr_valid;
  assign tx_raw_hdr_ready = tx_raw.hdr_ready;
  assign tx_raw.hdr       = tx_raw_hdr;
  assign tx_raw.tdata     = tx_raw_tdata;
  assign tx_raw.tkeep     = tx_raw_tkeep;
  assign tx_raw.tvalid    = tx_raw_tvalid;
  assign tx_raw_tready    = tx_raw.tready;
  assign tx_raw.tlast     = tx_raw_tlast;
  assign tx_raw.tuser     = tx_raw_tuser;

  assign tx_out_hdr_valid = tx_out.hdr_valid;
  assign tx_out.hdr_ready = tx_out_hdr_ready;
  assign tx_out_hdr       = tx_out.hdr;
  assign tx_out_tdata     = tx_out.tdata;
  assign tx_out_tkeep     = tx_out.tkeep;
  assign tx_out_tvalid    = tx_out.tvalid;
  assign tx_out.tready    = tx_out_tready;
  assign tx_out_tlast     = tx_out.tlast;
  assign tx_out_tuser     = tx_out.tuser;

  ip_rx_classifier ip_rx_classifier_inst (
    .clk   (clk),
    .rst   (rst),
    .in    (rx_in.sink),
    .udp   (rx_udp.source),
    .other (rx_other.source),
    .busy  (rx_busy)
  );

  ip_tx_arbiter ip_tx_arbiter_inst (
    .clk  (clk),
    .rst  (rst),
    .udp  (tx_udp.sink),
    .raw  (tx_raw.sink),
    .out  (tx_out.source),
    .busy (tx_busy)
  );

endmodule

// ==== hdl/ip_tx_arbiter.sv ====
module ip_tx_arbiter (
  input  logic        clk,
  input  logic        rst,
  ip_stream_if.sink   udp,
  ip_stream_if.sink   raw,
  ip_stream_if.source out,
  output logic        busy
);
  import ip_switch_pkg::*;

  tx_grant_e state;
  tx_grant_e state_next;
  logic      sel_udp;
  logic      in_hdr;
  logic      in_data;
  logic      hdr_xfer;
  logic      last_xfer;

  assign sel_udp = (state == grant_udp_hdr) || (state == grant_udp_data);
  assign in_hdr  = (state == grant_udp_hdr) || (state == grant_raw_hdr);
  assign in_data = (state == grant_udp_data) || (state == grant_raw_data);

  // Header from the granted source, one cycle after the grant
  assign out.hdr_valid = in_hdr && (sel_udp ? udp.hdr_valid : raw.hdr_valid);
  assign out.hdr       = sel_udp ? udp.hdr : raw.hdr;
  assign udp.hdr_ready = (state == grant_udp_hdr) && out.hdr_ready;
  assign raw.hdr_ready = (state == grant_raw_hdr) && out.hdr_ready;

  assign out.tvalid = in_data && (sel_udp ? udp.tvalid : raw.tvalid);
  assign out.tdata  = sel_udp ? udp.tdata : raw.tdata;
  assign out.tkeep  = sel_udp ? udp.tkeep : raw.tkeep;
  assign out.tlast  = sel_udp ? udp.tlast : raw.tlast;
  assign out.tuser  = sel_udp ? udp.tuser : raw.tuser;
  assign udp.tready = (state == grant_udp_data) && out.tready;
  assign raw.tready = (state == grant_raw_data) && out.tready;

  assign hdr_xfer  = out.hdr_valid && out.hdr_ready;
  assign last_xfer = out.tvalid && out.tready && out.tlast;

  always_comb begin
    state_next = state;
    case (state)
      grant_idle: begin
        // UDP wins when both are pending
        if (udp.hdr_valid) begin
          state_next = grant_udp_hdr;
        end else if (raw.hdr_valid) begin
          state_next = grant_raw_hdr;
        end
      end
      grant_udp_hdr: begin
        if (hdr_xfer) begin
          state_next = grant_udp_data;
        end
      end
      grant_raw_hdr: begin
        if (hdr_xfer) begin
          state_next = grant_raw_data;
        end
      end
      grant_udp_data, grant_raw_data: begin
        if (last_xfer) begin
          state_next = grant_idle;
        end
      end
      default: state_next = grant_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= grant_idle;
    end else begin
      state <= state_next;
    end
  end

  assign busy = (state != grant_idle);

endmodule

// ==== hdl/ip_rx_classifier.sv ====
`include "ip_switch_cfg.svh"

module ip_rx_classifier (
  input  logic        clk,
  input  logic        rst,
  ip_stream_if.sink   in,
  ip_stream_if.source udp,
  ip_stream_if.source other,
  output logic        busy
);
  import ip_switch_pkg::*;

  rx_route_e state;
  rx_route_e state_next;
  logic      hdr_is_udp;
  logic      hdr_xfer;
  logic      last_xfer;

  assign hdr_is_udp = (in.hdr.protocol == 8'(`IP_PROTO_UDP));

  // Headers only leave idle, so a payload never runs ahead of its header
  assign udp.hdr_valid   = in.hdr_valid && (state == route_idle) && hdr_is_udp;
  assign other.hdr_valid = in.hdr_valid && (state == route_idle) && !hdr_is_udp;
  assign in.hdr_ready    = (state == route_idle) &&
                           (hdr_is_udp ? udp.hdr_ready : other.hdr_ready);

  assign udp.hdr   = in.hdr;
  assign other.hdr = in.hdr;

  // Payload follows the locked route
  assign udp.tvalid   = in.tvalid && (state == route_udp);
  assign other.tvalid = in.tvalid && (state == route_other);
  assign in.tready    = ((state == route_udp) && udp.tready) ||
                        ((state == route_other) && other.tready);

  assign udp.tdata   = in.tdata;
  assign udp.tkeep   = in.tkeep;
  assign udp.tlast   = in.tlast;
  assign udp.tuser   = in.tuser;
  assign other.tdata = in.tdata;
  assign other.tkeep = in.tkeep;
  assign other.tlast = in.tlast;
  assign other.tuser = in.tuser;

  assign hdr_xfer  = in.hdr_valid && in.hdr_ready;
  assign last_xfer = in.tvalid && in.tready && in.tlast;

  always_comb begin
    state_next = state;
    case (state)
      route_idle: begin
        if (hdr_xfer) begin
          state_next = hdr_is_udp ? route_udp : route_other;
        end
      end
      route_udp, route_other: begin
        if (last_xfer) begin
          state_next = route_idle;
        end
      end
      default: state_next = route_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= route_idle;
    end else begin
      state <= state_next;
    end
  end

  assign busy = (state != route_idle);

endmodule

// ==== hdl/ip_stream_if.sv ====
`include "ip_switch_cfg.svh"

interface ip_stream_if;
  import ip_switch_pkg::*;

  // Header channel
  logic    hdr_valid;
  logic    hdr_ready;
  ip_hdr_t hdr;

  // Payload channel
  logic [`IP_DATA_W-1:0] tdata;
  logic [`IP_KEEP_W-1:0] tkeep;
  logic                  tvalid;
  logic                  tready;
  logic                  tlast;
  logic                  tuser;

  modport source (
    output hdr_valid,
    input  hdr_ready,
    output hdr,
    output tdata,
    output tkeep,
    output tvalid,
    input  tready,
    output tlast,
    output tuser
  );

  modport sink (
    input  hdr_valid,
    output hdr_ready,
    input  hdr,
    input  tdata,
    input  tkeep,
    input  tvalid,
    output tready,
    input  tlast,
    input  tuser
  );

endinterface

// ==== hdl/ip_switch_pkg.sv ====
`include "ip_switch_cfg.svh"

package ip_switch_pkg;

  // Header fields forwarded between the IP and UDP layers
  typedef struct packed {
    logic [5:0]            dscp;
    logic [1:0]            ecn;
    logic [15:0]           length;
    logic [7:0]            ttl;
    logic [7:0]            protocol;
    logic [`IP_ADDR_W-1:0] source_ip;
    logic [`IP_ADDR_W-1:0] dest_ip;
  } ip_hdr_t;

  typedef enum logic [1:0] {
    route_idle,
    route_udp,
    route_other
  } rx_route_e;

  typedef enum logic [2:0] {
    grant_idle,
    grant_udp_hdr,
    grant_raw_hdr,
    grant_udp_data,
    grant_raw_data
  } tx_grant_e;

endpackage

// ==== hdl/ip_switch_cfg.svh ====
`ifndef IP_SWITCH_CFG_SVH
`define IP_SWITCH_CFG_SVH

// Payload stream widths
`define IP_DATA_W 64
`define IP_KEEP_W 8

`define IP_ADDR_W 32

// IPv4 protocol number routed to the UDP path
`define IP_PROTO_UDP 17

`endif
